/* ccu_defines.svh */
// Width and depth constants of the configuration control unit.
// Included by the package and by any module that sizes storage directly.
`ifndef CCU_DEFINES_SVH
`define CCU_DEFINES_SVH

// ==============================
// Datapath widths
// ==============================
`define CCU_ITF_WIDTH        256  // One interface beat
`define CCU_ISA_WIDTH        128  // One instruction word
`define CCU_DRAM_ADDR_WIDTH  32

// ==============================
// Buffer
// ==============================
`define CCU_ISA_DEPTH        64   // Depth in words (power of two)

// ==============================
// Layer configuration fields
// ==============================
`define CCU_IDX_WIDTH        16   // Pixel count
`define CCU_CHN_WIDTH        12   // Channel count
`define CCU_ACT_WIDTH        8    // Shift and zero point
`define CCU_MAP_WIDTH        6    // Pooling kernel
`define CCU_LAYER_WIDTH      20
`define CCU_SCALE_WIDTH      20

`endif

/* ccuPkg.sv */
// Shared types of the configuration control unit.
// Imported by every design module that carries instruction words,
// buffer pointers or decoded configuration fields.
`default_nettype none

`include "ccu_defines.svh"

package ccuPkg;

    // ==============================
    // Data and buffer types
    // ==============================
    typedef logic [`CCU_ITF_WIDTH-1:0]          itfBeat_t;
    typedef logic [`CCU_ISA_WIDTH-1:0]          isaWord_t;
    typedef logic [$clog2(`CCU_ISA_DEPTH):0]    isaPtr_t;    // Extra bit tells full from empty
    typedef logic [$clog2(`CCU_ISA_DEPTH):0]    isaCount_t;

    // ==============================
    // Configuration fields
    // ==============================
    typedef logic [`CCU_DRAM_ADDR_WIDTH-1:0]    dramAddr_t;
    typedef logic [`CCU_IDX_WIDTH-1:0]          pixIdx_t;
    typedef logic [`CCU_CHN_WIDTH-1:0]          chnCnt_t;
    typedef logic [`CCU_ACT_WIDTH-1:0]          actByte_t;
    typedef logic [`CCU_SCALE_WIDTH-1:0]        scale_t;
    typedef logic [1:0]                         saMode_t;
    typedef logic [`CCU_MAP_WIDTH-1:0]          poolK_t;
    typedef logic [`CCU_LAYER_WIDTH-1:0]        layerCnt_t;

    // Opcode in bits [7:0] of every instruction word
    typedef enum logic [7:0] {
        OP_NET  = 8'd0,
        OP_CONV = 8'd1,
        OP_POOL = 8'd2
    } opcode_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_READ,
        S_DECODE,
        S_WAIT_CFG,
        S_DONE
    } seqState_t;

endpackage

`default_nettype wire

/* isaBufIf.sv */
// Read path of the instruction buffer.
// The sequencer requests words, the buffer returns them one cycle later
// to the decoder, and reports its full and empty flags to the sequencer.
`timescale 1ns/100ps
`default_nettype none

interface isaBufIf
    import ccuPkg::*;
();

    logic     rdEn;       // Read request for one word
    isaWord_t rdData;
    logic     rdDataVld;  // rdData valid one cycle after rdEn
    logic     empty;
    logic     full;

    modport buffer (
        input  rdEn,
        output rdData,
        output rdDataVld,
        output empty,
        output full
    );

    modport sequencer (
        output rdEn,
        input  empty,
        input  full
    );

    modport decoder (
        input  rdData,
        input  rdDataVld
    );

endinterface

`default_nettype wire

/* isaWidthConv.sv */
// Splits each 256-bit interface beat into two instruction words.
// A beat is only taken while fetching and with nothing held; the low
// half goes out first, then the high half, both on a valid/ready pair.
`timescale 1ns/100ps
`default_nettype none

module isaWidthConv
    import ccuPkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fetchEn,
    input  itfBeat_t beat,
    input  logic     beatVld,
    output logic     beatRdy,
    output isaWord_t word,
    output logic     wordVld,
    input  logic     wordRdy
);

    localparam int WordWidth = $bits(isaWord_t);

    itfBeat_t holdBeat;
    logic     loaded;    // A beat is held
    logic     hiSel;     // Low half already sent
    logic     beatTake;
    logic     wordTake;

    assign beatRdy  = fetchEn && !loaded;
    assign beatTake = beatVld && beatRdy;
    assign wordVld  = loaded;
    assign wordTake = wordVld && wordRdy;
    assign word     = hiSel ? holdBeat[WordWidth +: WordWidth] : holdBeat[0 +: WordWidth];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            loaded <= 1'b0;
            hiSel  <= 1'b0;
        end else if (beatTake) begin
            loaded <= 1'b1;
            hiSel  <= 1'b0;
        end else if (wordTake) begin
            loaded <= !hiSel;    // Free after the high half
            hiSel  <= !hiSel;
        end
    end

    always_ff @(posedge clk) begin
        if (beatTake) begin
            holdBeat <= beat;
        end
    end

endmodule

`default_nettype wire

/* isaBuffer.sv */
// Instruction buffer, 64 words of 128 bits, one writer and one reader.
// Words come in from the width converter on a valid/ready pair and are
// read in order through isaBufIf; read data is registered.
// The free count feeds the interface request number.
`timescale 1ns/100ps
`default_nettype none

`include "ccu_defines.svh"

module isaBuffer
    import ccuPkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      clear,
    input  isaWord_t  word,
    input  logic      wordVld,
    output logic      wordRdy,
    output isaCount_t freeCount,
    isaBufIf.buffer   rd
);

    localparam int        AddrWidth = $clog2(`CCU_ISA_DEPTH);
    localparam isaCount_t Depth     = isaCount_t'(`CCU_ISA_DEPTH);

    isaWord_t  mem [`CCU_ISA_DEPTH];
    isaPtr_t   wrPtr;
    isaPtr_t   rdPtr;
    isaCount_t fill;
    logic      wrEn;
    logic      rdGo;

    // ==============================
    // Flags from pointer difference
    // ==============================
    assign fill      = isaCount_t'(wrPtr - rdPtr);
    assign rd.full   = (fill == Depth);
    assign rd.empty  = (fill == '0);
    assign freeCount = Depth - fill;
    assign wordRdy   = !rd.full;

    assign wrEn = wordVld && wordRdy;
    assign rdGo = rd.rdEn && !rd.empty;    // Never read past the write pointer

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            rd.rdDataVld <= 1'b0;
        end else if (clear) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            rd.rdDataVld <= 1'b0;
        end else begin
            if (wrEn) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (rdGo) begin
                rdPtr <= rdPtr + 1'b1;
            end
            rd.rdDataVld <= rdGo;
        end
    end

    // RAM array and read register
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrPtr[AddrWidth-1:0]] <= word;
        end
        if (rdGo) begin
            rd.rdData <= mem[rdPtr[AddrWidth-1:0]];
        end
    end

endmodule

`default_nettype wire

/* isaDecoder.sv */
// Instruction decoder. Takes each word read from the buffer, latches the
// fields by opcode and word index, and raises the systolic-array or the
// pooling configuration valid once an instruction is complete. Counts
// transferred layers against the header count for the sequencer.
`timescale 1ns/100ps
`default_nettype none

module isaDecoder
    import ccuPkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      clear,
    isaBufIf.decoder  rd,
    output logic      cfgPending,
    output logic      netComplete,
    // Systolic array
    output logic      saCfgVld,
    input  logic      saCfgRdy,
    output pixIdx_t   saNip,
    output chnCnt_t   saChi,
    output scale_t    saScale,
    output actByte_t  saShift,
    output actByte_t  saZp,
    output saMode_t   saMode,
    // Pooling
    output logic      poolCfgVld,
    input  logic      poolCfgRdy,
    output pixIdx_t   poolNip,
    output chnCnt_t   poolChi,
    output poolK_t    poolK,
    // DRAM base addresses
    output dramAddr_t dramActAddr,
    output dramAddr_t dramWgtAddr,
    output dramAddr_t dramOfmAddr,
    output dramAddr_t dramMapAddr
);

    opcode_t   op;
    logic      convWord;     // Second convolution word expected
    layerCnt_t numLayers;    // From the network header
    layerCnt_t layerCnt;     // Layers handed out so far
    logic      saLoad;
    logic      poolLoad;
    logic      saXfer;
    logic      poolXfer;

    assign op       = opcode_t'(rd.rdData[7:0]);
    assign saLoad   = rd.rdDataVld && (op == OP_CONV) && convWord;
    assign poolLoad = rd.rdDataVld && (op == OP_POOL);
    assign saXfer   = saCfgVld && saCfgRdy;
    assign poolXfer = poolCfgVld && poolCfgRdy;

    // Busy from the last word until the transfer cycle
    assign cfgPending = saLoad || poolLoad
                     || (saCfgVld && !saCfgRdy)
                     || (poolCfgVld && !poolCfgRdy);

    assign netComplete = (numLayers != '0) && (layerCnt == numLayers);

    // ==============================
    // Control state
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            convWord   <= 1'b0;
            numLayers  <= '0;
            layerCnt   <= '0;
            saCfgVld   <= 1'b0;
            poolCfgVld <= 1'b0;
        end else if (clear) begin
            convWord   <= 1'b0;
            numLayers  <= '0;
            layerCnt   <= '0;
            saCfgVld   <= 1'b0;
            poolCfgVld <= 1'b0;
        end else begin
            if (rd.rdDataVld) begin
                convWord <= (op == OP_CONV) && !convWord;
                if (op == OP_NET) begin
                    numLayers <= rd.rdData[27:8];
                end
            end
            if (saLoad) begin
                saCfgVld <= 1'b1;
            end else if (saXfer) begin
                saCfgVld <= 1'b0;
            end
            if (poolLoad) begin
                poolCfgVld <= 1'b1;
            end else if (poolXfer) begin
                poolCfgVld <= 1'b0;
            end
            if (saXfer || poolXfer) begin
                layerCnt <= layerCnt + 1'b1;
            end
        end
    end

    // ==============================
    // Field capture
    // ==============================
    always_ff @(posedge clk) begin
        if (rd.rdDataVld) begin
            case (op)
                OP_CONV: begin
                    if (!convWord) begin
                        dramActAddr <= rd.rdData[39:8];
                        dramWgtAddr <= rd.rdData[71:40];
                        dramOfmAddr <= rd.rdData[103:72];
                    end else begin
                        saNip   <= rd.rdData[23:8];
                        saChi   <= rd.rdData[35:24];
                        saScale <= rd.rdData[55:36];
                        saShift <= rd.rdData[63:56];
                        saZp    <= rd.rdData[71:64];
                        saMode  <= rd.rdData[73:72];
                    end
                end
                OP_POOL: begin
                    dramMapAddr <= rd.rdData[39:8];
                    poolNip     <= rd.rdData[55:40];
                    poolChi     <= rd.rdData[67:56];
                    poolK       <= rd.rdData[73:68];
                end
                default: ;    // Header is latched above and other opcodes dropped
            endcase
        end
    end

endmodule

`default_nettype wire

/* ccuSequencer.sv */
// Top state machine of the unit. Fetches until the buffer is full, reads
// words one at a time, waits for each configuration to be taken and
// pulses netDone once the header's layer count is reached.
`timescale 1ns/100ps
`default_nettype none

module ccuSequencer
    import ccuPkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    isaBufIf.sequencer  rd,
    input  logic        cfgPending,
    input  logic        netComplete,
    output logic        fetchEn,
    output logic        clear,
    output logic        netDone
);

    seqState_t state;
    seqState_t nextState;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            S_IDLE:     if (start) nextState = S_FETCH;
            S_FETCH:    if (rd.full) nextState = S_READ;
            S_READ: begin
                if (netComplete) begin
                    nextState = S_DONE;
                end else if (rd.empty) begin
                    nextState = S_FETCH;    // Refill from empty
                end else begin
                    nextState = S_DECODE;
                end
            end
            S_DECODE: begin
                if (cfgPending) begin
                    nextState = S_WAIT_CFG;
                end else begin
                    nextState = S_READ;
                end
            end
            S_WAIT_CFG: if (!cfgPending) nextState = S_READ;
            S_DONE:     nextState = S_IDLE;
            default:    nextState = S_IDLE;
        endcase
    end

    assign rd.rdEn = (state == S_READ) && !netComplete && !rd.empty;
    // No new beat once full, so nothing stays in the converter after fetch
    assign fetchEn = (state == S_FETCH) && !rd.full;
    assign clear   = (state == S_IDLE);
    assign netDone = (state == S_DONE);

endmodule

`default_nettype wire

/* ccuTop.sv */
// Configuration control unit, top level with plain ports.
// Chain of width converter, instruction buffer, decoder and sequencer.
// Pulse start to fetch and run a program; netDone marks its end.
`timescale 1ns/100ps
`default_nettype none

module ccuTop
    import ccuPkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    // Instruction interface
    input  itfBeat_t  itfDat,
    input  logic      itfDatVld,
    output logic      itfDatRdy,
    output isaCount_t itfReqNum,
    output logic      netDone,
    // Systolic array configuration
    output logic      saCfgVld,
    input  logic      saCfgRdy,
    output pixIdx_t   saNip,
    output chnCnt_t   saChi,
    output scale_t    saScale,
    output actByte_t  saShift,
    output actByte_t  saZp,
    output saMode_t   saMode,
    // Pooling configuration
    output logic      poolCfgVld,
    input  logic      poolCfgRdy,
    output pixIdx_t   poolNip,
    output chnCnt_t   poolChi,
    output poolK_t    poolK,
    // DRAM base addresses
    output dramAddr_t dramActAddr,
    output dramAddr_t dramWgtAddr,
    output dramAddr_t dramOfmAddr,
    output dramAddr_t dramMapAddr
);

    logic     fetchEn;
    logic     clear;
    logic     cfgPending;
    logic     netComplete;
    isaWord_t word;
    logic     wordVld;
    logic     wordRdy;

    isaBufIf bufIf ();

    isaWidthConv widthConv_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .fetchEn (fetchEn),
        .beat    (itfDat),
        .beatVld (itfDatVld),
        .beatRdy (itfDatRdy),
        .word    (word),
        .wordVld (wordVld),
        .wordRdy (wordRdy)
    );

    isaBuffer isaBuffer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .word      (word),
        .wordVld   (wordVld),
        .wordRdy   (wordRdy),
        .freeCount (itfReqNum),
        .rd        (bufIf.buffer)
    );

    isaDecoder isaDecoder_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear       (clear),
        .rd          (bufIf.decoder),
        .cfgPending  (cfgPending),
        .netComplete (netComplete),
        .saCfgVld    (saCfgVld),
        .saCfgRdy    (saCfgRdy),
        .saNip       (saNip),
        .saChi       (saChi),
        .saScale     (saScale),
        .saShift     (saShift),
        .saZp        (saZp),
        .saMode      (saMode),
        .poolCfgVld  (poolCfgVld),
        .poolCfgRdy  (poolCfgRdy),
        .poolNip     (poolNip),
        .poolChi     (poolChi),
        .poolK       (poolK),
        .dramActAddr (dramActAddr),
        .dramWgtAddr (dramWgtAddr),
        .dramOfmAddr (dramOfmAddr),
        .dramMapAddr (dramMapAddr)
    );

    ccuSequencer ccuSequencer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .rd          (bufIf.sequencer),
        .cfgPending  (cfgPending),
        .netComplete (netComplete),
        .fetchEn     (fetchEn),
        .clear       (clear),
        .netDone     (netDone)
    );

endmodule

`default_nettype wire

/* tbClkGen.sv */
// Free-running clock for the testbench.
// Starts low and toggles every half period.
`timescale 1ns/100ps
`default_nettype none

module tbClkGen #(
    parameter real PeriodNs = 10.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2.0) clk = !clk;
    end

endmodule

`default_nettype wire

/* ccu_properties.sv */
// Protocol assertions for the configuration control unit.
// Bound to ccuTop below; fields of each configuration come in as one vector.
`timescale 1ns/100ps
`default_nettype none

module ccu_properties
    import ccuPkg::*;
#(
    parameter int SaWidth   = $bits(pixIdx_t) + $bits(chnCnt_t) + $bits(scale_t)
                            + 2 * $bits(actByte_t) + $bits(saMode_t) + 3 * $bits(dramAddr_t),
    parameter int PoolWidth = $bits(pixIdx_t) + $bits(chnCnt_t) + $bits(poolK_t)
                            + $bits(dramAddr_t)
) (
    input logic                 clk,
    input logic                 rst_n,
    input seqState_t            seqState,
    input logic                 itfDatRdy,
    input logic                 netDone,
    input logic                 saCfgVld,
    input logic                 saCfgRdy,
    input logic [SaWidth-1:0]   saFields,
    input logic                 poolCfgVld,
    input logic                 poolCfgRdy,
    input logic [PoolWidth-1:0] poolFields
);

    int failCount = 0;    // Assertion failures so far

    // ==============================
    // Configuration handshakes
    // ==============================
    saHoldA: assert property (@(posedge clk) disable iff (!rst_n)
        saCfgVld && !saCfgRdy |=> saCfgVld && $stable(saFields))
    else begin
        failCount++;
        $error("SA valid dropped or fields changed before ready");
    end

    saDropA: assert property (@(posedge clk) disable iff (!rst_n)
        saCfgVld && saCfgRdy |=> !saCfgVld)
    else begin
        failCount++;
        $error("SA valid still high after transfer");
    end

    poolHoldA: assert property (@(posedge clk) disable iff (!rst_n)
        poolCfgVld && !poolCfgRdy |=> poolCfgVld && $stable(poolFields))
    else begin
        failCount++;
        $error("Pooling valid dropped or fields changed before ready");
    end

    poolDropA: assert property (@(posedge clk) disable iff (!rst_n)
        poolCfgVld && poolCfgRdy |=> !poolCfgVld)
    else begin
        failCount++;
        $error("Pooling valid still high after transfer");
    end

    // ==============================
    // Sequencing
    // ==============================
    doneA: assert property (@(posedge clk) disable iff (!rst_n) netDone |=> !netDone)
    else begin
        failCount++;
        $error("netDone longer than one cycle");
    end

    itfRdyA: assert property (@(posedge clk) disable iff (!rst_n)
        itfDatRdy |-> seqState == S_FETCH)
    else begin
        failCount++;
        $error("itfDatRdy high outside fetch");
    end

endmodule

bind ccuTop ccu_properties props_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .seqState   (ccuSequencer_i.state),
    .itfDatRdy  (itfDatRdy),
    .netDone    (netDone),
    .saCfgVld   (saCfgVld),
    .saCfgRdy   (saCfgRdy),
    .saFields   ({saNip, saChi, saScale, saShift, saZp, saMode,
                  dramActAddr, dramWgtAddr, dramOfmAddr}),
    .poolCfgVld (poolCfgVld),
    .poolCfgRdy (poolCfgRdy),
    .poolFields ({poolNip, poolChi, poolK, dramMapAddr})
);

`default_nettype wire

/* ccuTb.sv */
// Testbench for the configuration control unit.
// Builds random programs with an LCG, streams them over the interface
// with random gaps, and checks every configuration transfer against a
// queue model under random ready delays. Runs several programs back to back.
`timescale 1ns/100ps
`default_nettype none

module ccuTb
    import ccuPkg::*;
();

    localparam logic [31:0] Seed        = 32'd1;
    localparam int          NumRuns     = 3;
    localparam int          DoneTimeout = 20000;    // Cycles per program

    typedef struct packed {
        pixIdx_t  nip;
        chnCnt_t  chi;
        scale_t   scale;
        actByte_t shift;
        actByte_t zp;
        saMode_t  mode;
    } saCfg_t;

    typedef struct packed {
        pixIdx_t nip;
        chnCnt_t chi;
        poolK_t  k;
    } poolCfg_t;

    logic      clk;
    logic      rst_n;
    logic      start;
    itfBeat_t  itfDat;
    logic      itfDatVld;
    logic      itfDatRdy;
    isaCount_t itfReqNum;
    logic      netDone;
    logic      saCfgVld;
    logic      saCfgRdy;
    pixIdx_t   saNip;
    chnCnt_t   saChi;
    scale_t    saScale;
    actByte_t  saShift;
    actByte_t  saZp;
    saMode_t   saMode;
    logic      poolCfgVld;
    logic      poolCfgRdy;
    pixIdx_t   poolNip;
    chnCnt_t   poolChi;
    poolK_t    poolK;
    dramAddr_t dramActAddr;
    dramAddr_t dramWgtAddr;
    dramAddr_t dramOfmAddr;
    dramAddr_t dramMapAddr;

    // Reference model with one entry per expected transfer
    saCfg_t    saExpQ[$];
    poolCfg_t  poolExpQ[$];
    dramAddr_t actQ[$];
    dramAddr_t wgtQ[$];
    dramAddr_t ofmQ[$];
    dramAddr_t mapQ[$];
    itfBeat_t  beatQ[$];    // Program beats still to send

    logic [31:0] progState;
    logic [31:0] itfState;
    logic [31:0] saState;
    logic [31:0] poolState;
    int          mismatchCount;
    int          protocolCount;
    int          fillCnt;
    logic        running;      // Between start and netDone
    logic        flushBeat;    // Drop the beat on offer when a new program is loaded

    tbClkGen clkGen_i (.clk(clk));

    ccuTop ccuTop_i (.*);

    // ==============================
    // Random numbers
    // ==============================
    function automatic logic [31:0] lcgStep(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] nextProgRand();
        logic [31:0] hi;
        progState = lcgStep(progState);
        hi        = progState;
        progState = lcgStep(progState);
        return {hi[31:16], progState[31:16]};    // Upper bits only
    endfunction

    function automatic isaWord_t randWord();
        return {nextProgRand(), nextProgRand(), nextProgRand(), nextProgRand()};
    endfunction

    function automatic isaWord_t unknownWord();
        isaWord_t w;
        w      = randWord();
        w[7:0] = 8'd3 + 8'(nextProgRand() % 253);
        return w;
    endfunction

    function automatic itfBeat_t fillerBeat();
        fillCnt++;
        return {120'(fillCnt), 8'hEE, 120'(fillCnt), 8'hEF};
    endfunction

    // ==============================
    // Compare tasks
    // ==============================
    task automatic saCfgMatch(input saCfg_t exp, input saCfg_t got);
        if (got !== exp) begin
            mismatchCount++;
            $display("FAILED at %0t: SA config got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic poolCfgMatch(input poolCfg_t exp, input poolCfg_t got);
        if (got !== exp) begin
            mismatchCount++;
            $display("FAILED at %0t: pooling config got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic addrMatch(input string name, input dramAddr_t exp, input dramAddr_t got);
        if (got !== exp) begin
            mismatchCount++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic countMatch(input string name, input isaCount_t exp, input isaCount_t got);
        if (got !== exp) begin
            mismatchCount++;
            $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic flagMatch(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            mismatchCount++;
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // ==============================
    // Program generation
    // ==============================
    task automatic buildProgram(input layerCnt_t layers);
        isaWord_t  words[$];
        isaWord_t  w;
        saCfg_t    sa;
        poolCfg_t  pc;
        dramAddr_t addr;
        int        made;
        int        i;
        made    = 0;
        w       = randWord();
        w[7:0]  = OP_NET;
        w[27:8] = layers;
        words.push_back(w);
        while (made < layers) begin
            if (nextProgRand() % 4 == 0) begin
                words.push_back(unknownWord());    // Must not produce a transfer
            end
            if (nextProgRand() % 2 == 0) begin
                w        = randWord();
                w[7:0]   = OP_CONV;
                actQ.push_back(w[39:8]);
                wgtQ.push_back(w[71:40]);
                ofmQ.push_back(w[103:72]);
                words.push_back(w);
                w        = randWord();
                sa       = w[$bits(saCfg_t)-1:0];
                w[7:0]   = OP_CONV;
                w[23:8]  = sa.nip;
                w[35:24] = sa.chi;
                w[55:36] = sa.scale;
                w[63:56] = sa.shift;
                w[71:64] = sa.zp;
                w[73:72] = sa.mode;
                saExpQ.push_back(sa);
                words.push_back(w);
            end else begin
                w        = randWord();
                pc       = w[$bits(poolCfg_t)-1:0];
                addr     = nextProgRand();
                w[7:0]   = OP_POOL;
                w[39:8]  = addr;
                w[55:40] = pc.nip;
                w[67:56] = pc.chi;
                w[73:68] = pc.k;
                poolExpQ.push_back(pc);
                mapQ.push_back(addr);
                words.push_back(w);
            end
            made++;
        end
        if (words.size() % 2 != 0) begin
            words.push_back(unknownWord());
        end
        beatQ.delete();
        for (i = 0; i < words.size(); i += 2) begin
            beatQ.push_back({words[i+1], words[i]});    // Low half goes first
        end
        flushBeat = 1'b1;
    endtask

    task automatic pulseStart();
        @(posedge clk);
        #1;
        start   = 1'b1;
        running = 1'b1;
        @(posedge clk);
        #1;
        start   = 1'b0;
    endtask

    task automatic waitNetDone(input int run);
        logic seen;
        int   cyc;
        seen = 1'b0;
        for (cyc = 0; cyc < DoneTimeout && !seen; cyc++) begin
            @(negedge clk);
            seen = netDone;
        end
        if (!seen) begin
            $display("Timeout: no netDone within %0d cycles in run %0d", DoneTimeout, run);
            $display("Errors: %0d mismatches, %0d protocol, %0d assertion failures",
                     mismatchCount, protocolCount + 1, ccuTop_i.props_i.failCount);
            $display("Result: FAILED");
            $finish;
        end
    endtask

    // ==============================
    // Interface driver
    // ==============================
    always begin : itfDriver
        logic taken;
        @(negedge clk);
        taken = itfDatVld && itfDatRdy;
        @(posedge clk);
        #1;
        if (taken && beatQ.size() != 0) begin
            void'(beatQ.pop_front());
        end
        if (flushBeat) begin
            itfDatVld = 1'b0;
            flushBeat = 1'b0;
        end else if (!itfDatVld || taken) begin
            itfState  = lcgStep(itfState);
            itfDatVld = (itfState[31:30] != 2'b00);    // Gap about one cycle in four
            itfDat    = (beatQ.size() != 0) ? beatQ[0] : fillerBeat();
        end
    end

    // Random ready delays
    always @(posedge clk) begin
        #1;
        saState    = lcgStep(saState);
        poolState  = lcgStep(poolState);
        saCfgRdy   = saState[31];
        poolCfgRdy = (poolState[31:30] != 2'b00);
    end

    // ==============================
    // Transfer monitor
    // ==============================
    always @(negedge clk) begin : cfgMonitor
        saCfg_t   saGot;
        poolCfg_t poolGot;
        if (rst_n && saCfgVld && saCfgRdy) begin
            saGot = {saNip, saChi, saScale, saShift, saZp, saMode};
            if (!running || saExpQ.size() == 0) begin
                protocolCount++;
                $display("Unexpected SA configuration transfer at %0t", $time);
            end else begin
                saCfgMatch(saExpQ.pop_front(), saGot);
                addrMatch("dramActAddr", actQ.pop_front(), dramActAddr);
                addrMatch("dramWgtAddr", wgtQ.pop_front(), dramWgtAddr);
                addrMatch("dramOfmAddr", ofmQ.pop_front(), dramOfmAddr);
            end
        end
        if (rst_n && poolCfgVld && poolCfgRdy) begin
            poolGot = {poolNip, poolChi, poolK};
            if (!running || poolExpQ.size() == 0) begin
                protocolCount++;
                $display("Unexpected pooling configuration transfer at %0t", $time);
            end else begin
                poolCfgMatch(poolExpQ.pop_front(), poolGot);
                addrMatch("dramMapAddr", mapQ.pop_front(), dramMapAddr);
            end
        end
    end

    // ==============================
    // Main sequence
    // ==============================
    initial begin : mainSeq
        layerCnt_t layers;
        int        run;
        int        cyc;
        progState     = Seed;
        itfState      = Seed ^ 32'h9E37_79B9;
        saState       = Seed ^ 32'h7F4A_7C15;
        poolState     = Seed ^ 32'h2545_F491;
        mismatchCount = 0;
        protocolCount = 0;
        fillCnt       = 0;
        running       = 1'b0;
        flushBeat     = 1'b0;
        rst_n         = 1'b0;
        start         = 1'b0;
        itfDat        = '0;
        itfDatVld     = 1'b0;
        saCfgRdy      = 1'b0;
        poolCfgRdy    = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        flagMatch("itfDatRdy after reset", 1'b0, itfDatRdy);
        flagMatch("saCfgVld after reset", 1'b0, saCfgVld);
        flagMatch("poolCfgVld after reset", 1'b0, poolCfgVld);
        flagMatch("netDone after reset", 1'b0, netDone);
        countMatch("itfReqNum after reset", isaCount_t'(64), itfReqNum);

        for (run = 0; run < NumRuns; run++) begin
            // Last program holds more words than the buffer and needs a refetch
            layers = (run == NumRuns - 1) ? layerCnt_t'(70)
                                          : layerCnt_t'(10 + nextProgRand() % 50);
            buildProgram(layers);
            pulseStart();
            waitNetDone(run);
            running = 1'b0;
            if (saExpQ.size() != 0 || poolExpQ.size() != 0) begin
                protocolCount++;
                $display("netDone in run %0d with %0d SA and %0d pooling configs outstanding",
                         run, saExpQ.size(), poolExpQ.size());
            end
            for (cyc = 0; cyc < 10; cyc++) begin
                @(negedge clk);
                if (netDone) begin
                    protocolCount++;
                    $display("Extra netDone at %0t in run %0d", $time, run);
                end
                if (cyc == 1) begin
                    countMatch("itfReqNum after done", isaCount_t'(64), itfReqNum);
                end
            end
        end

        $display("Errors: %0d mismatches, %0d protocol, %0d assertion failures",
                 mismatchCount, protocolCount, ccuTop_i.props_i.failCount);
        if (mismatchCount + protocolCount + ccuTop_i.props_i.failCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
ccuPkg.sv
isaBufIf.sv
isaWidthConv.sv
isaBuffer.sv
isaDecoder.sv
ccuSequencer.sv
ccuTop.sv
tbClkGen.sv
ccu_properties.sv
ccuTb.sv
